// File: bench/debug_tb.sv
module debug_tb;
    import debug_pkg::*;

    localparam int SEED           = 57017;
    localparam int NUM_TXN        = 400;
    localparam int CYCLES_PER_TXN = 40;
    localparam int RAND_TXN       = 300;
    localparam int CLK_HALF       = 10;

    logic                  i_clock;
    logic                  i_soft_reset;
    logic [AXI_ADDR_W-1:0] i_awaddr;
    logic                  i_awvalid;
    logic                  o_awready;
    logic [DATA_W-1:0]     i_wdata;
    logic                  i_wvalid;
    logic                  o_wready;
    logic [1:0]            o_bresp;
    logic                  o_bvalid;
    logic                  i_bready;
    logic [AXI_ADDR_W-1:0] i_araddr;
    logic                  i_arvalid;
    logic                  o_arready;
    logic [DATA_W-1:0]     o_rdata;
    logic [1:0]            o_rresp;
    logic                  o_rvalid;
    logic                  i_rready;
    logic [ADDR_W-1:0]     i_pc;
    logic [ADDR_W-1:0]     i_adder_pc;
    logic [DATA_W-1:0]     i_instr;
    logic [DATA_W-1:0]     i_data_a;
    logic [DATA_W-1:0]     i_data_b;
    logic [DATA_W-1:0]     i_alu_result;
    logic [DATA_W-1:0]     i_wb_data;
    logic [REG_IDX_W-1:0]  i_wb_dest;
    logic                  i_wb_reg_write;
    logic                  i_halt_wb;
    logic                  i_run;

    // Reference model.
    logic [DATA_W-1:0]  m_snap [8];                      // Packed snapshot words.
    logic [CYCLE_W-1:0] m_count;
    logic               m_halted;
    logic               m_captured;
    debug_word_e        m_sel;
    debug_cmd_e         op_cmd;
    int                 op_wait;                         // Edges until the command acts.
    logic [1:0]         exp_bresp;
    logic [1:0]         exp_rresp;
    logic [DATA_W-1:0]  exp_rdata;
    int                 halt_rate;                       // Zero means no halt pulses.
    logic               run_hold;

    debug_top u_dut (.*);

    always #CLK_HALF i_clock = ~i_clock;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input debug_word_e sel,
                              input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("** Error %s word %s: expected %h, actual %h",
                               name, sel.name(), exp, act));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("** Error %s response: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_status(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("** Error %s status: expected %h, actual %h", name, exp, act));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite driver.
    //////////////////////////////////////////////////////////////////////

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int gap;
        gap = $urandom_range(2);                         // Idle cycles before bready.
        i_awaddr  <= addr;
        i_wdata   <= data;
        i_awvalid <= 1'b1;
        i_wvalid  <= 1'b1;
        do begin
            @(posedge i_clock);
            if (o_wready !== o_awready) begin
                stop_run("The write data ready did not rise together with the address ready.");
            end
        end while (!o_awready);
        i_awvalid <= 1'b0;
        i_wvalid  <= 1'b0;
        do @(posedge i_clock); while (!o_bvalid);
        check_resp($sformatf("write %h to %h", data, addr), exp_bresp, o_bresp);
        repeat (gap) begin
            @(posedge i_clock);
            if (!o_bvalid) stop_run("The write response dropped before bready.");
        end
        i_bready <= 1'b1;
        @(posedge i_clock);
        i_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int gap;
        gap = $urandom_range(2);                         // Idle cycles before rready.
        i_araddr  <= addr;
        i_arvalid <= 1'b1;
        do @(posedge i_clock); while (!o_arready);
        i_arvalid <= 1'b0;
        do @(posedge i_clock); while (!o_rvalid);
        data = o_rdata;
        check_resp($sformatf("read of %h", addr), exp_rresp, o_rresp);
        repeat (gap) begin
            @(posedge i_clock);
            if (!o_rvalid) stop_run("The read data dropped before rready.");
        end
        i_rready <= 1'b1;
        @(posedge i_clock);
        i_rready <= 1'b0;
    endtask

    task automatic read_data(input string name);
        logic [DATA_W-1:0] rd;
        axi_read(REG_DATA, rd);
        check_word(name, m_sel, exp_rdata, rd);
    endtask

    task automatic read_status(input string name, output logic [DATA_W-1:0] rd);
        axi_read(REG_STATUS, rd);
        check_status(name, exp_rdata, rd);
    endtask

    task automatic read_all(input string name);
        for (int w = 0; w < 8; w++) begin
            axi_write(REG_SELECT, w);
            read_data(name);
        end
    endtask

    // New pipeline values every cycle.
    always @(posedge i_clock) begin
        i_pc           <= ADDR_W'($urandom);
        i_adder_pc     <= ADDR_W'($urandom);
        i_instr        <= $urandom;
        i_data_a       <= $urandom;
        i_data_b       <= $urandom;
        i_alu_result   <= $urandom;
        i_wb_data      <= $urandom;
        i_wb_dest      <= REG_IDX_W'($urandom);
        i_wb_reg_write <= 1'($urandom);
        i_halt_wb      <= (halt_rate != 0) && ($urandom_range(halt_rate - 1) == 0);
        i_run          <= !run_hold && ($urandom_range(3) != 0);
    end

    //////////////////////////////////////////////////////////////////////
    // Model update, one step per clock edge.
    //////////////////////////////////////////////////////////////////////

    always @(posedge i_clock) begin
        if (!i_soft_reset) begin
            foreach (m_snap[i]) m_snap[i] = '0;
            m_count    = '0;
            m_halted   = 1'b0;
            m_captured = 1'b0;
            m_sel      = W_PC_CYCLES;
            op_wait    = 0;
        end else begin
            if (o_arready) begin                         // Read address accepted.
                exp_rresp = RESP_OKAY;
                case (i_araddr)
                    REG_DATA:   exp_rdata = m_snap[m_sel];
                    REG_STATUS: exp_rdata = {m_captured, m_halted, 19'd0, m_count};
                    default:    exp_rdata = '0;
                endcase
            end
            if (op_wait == 1 && op_cmd == CMD_CLEAR) begin
                foreach (m_snap[i]) m_snap[i] = '0;
                m_count    = '0;
                m_halted   = 1'b0;
                m_captured = 1'b0;
            end else begin
                if (op_wait == 1 && op_cmd == CMD_CAPTURE) begin
                    m_snap[W_PC_CYCLES] = {i_pc, 10'd0, m_count};
                    m_snap[W_ADDER_PC]  = {21'd0, i_adder_pc};
                    m_snap[W_INSTR]     = i_instr;
                    m_snap[W_DATA_A]    = i_data_a;
                    m_snap[W_DATA_B]    = i_data_b;
                    m_snap[W_ALU]       = i_alu_result;
                    m_snap[W_WB_DATA]   = i_wb_data;
                    m_snap[W_WB_CTRL]   = {i_halt_wb, i_wb_reg_write, 25'd0, i_wb_dest};
                    m_captured          = 1'b1;
                end
                if (i_run && !m_halted && m_count != '1) m_count = m_count + 1'b1;
                if (i_halt_wb) m_halted = 1'b1;
            end
            if (op_wait != 0) op_wait = op_wait - 1;
            if (o_awready) begin                         // Write accepted.
                exp_bresp = RESP_OKAY;
                if (i_awaddr == REG_CMD && i_wdata <= 2) begin
                    if (i_wdata != 0) begin
                        op_cmd  = debug_cmd_e'(i_wdata[1:0]);
                        op_wait = 2;
                    end
                end else if (i_awaddr == REG_SELECT && i_wdata <= 7) begin
                    m_sel = debug_word_e'(i_wdata[2:0]);
                end else begin
                    exp_bresp = RESP_SLVERR;
                end
            end
        end
    end

    initial begin
        #(NUM_TXN * CYCLES_PER_TXN * 2 * CLK_HALF);
        $display("Watchdog expired after %0d cycles.", NUM_TXN * CYCLES_PER_TXN);
        $display("RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        logic [DATA_W-1:0] st;
        logic [DATA_W-1:0] st2;
        void'($urandom(SEED));
        i_clock      = 1'b0;
        i_soft_reset = 1'b0;
        {i_awaddr, i_awvalid, i_wdata, i_wvalid, i_bready} = '0;
        {i_araddr, i_arvalid, i_rready} = '0;
        {i_pc, i_adder_pc, i_instr, i_data_a, i_data_b, i_alu_result} = '0;
        {i_wb_data, i_wb_dest, i_wb_reg_write, i_halt_wb, i_run} = '0;
        halt_rate = 0;
        run_hold  = 1'b1;                                // Count held at zero.
        repeat (2) @(posedge i_clock);
        i_soft_reset <= 1'b1;
        @(posedge i_clock);
        read_all("reset");
        read_status("reset", st);

        run_hold <= 1'b0;
        repeat (7) @(posedge i_clock);
        axi_write(REG_CMD, CMD_CAPTURE);
        read_all("capture");
        axi_write(REG_SELECT, W_INSTR);
        axi_write(REG_CMD, 3);                           // Rejected writes.
        axi_write(REG_SELECT, 9);
        axi_write(REG_DATA, $urandom);
        axi_write(REG_STATUS, $urandom);
        read_data("rejected");
        read_status("rejected", st);

        run_hold <= 1'b1;
        read_status("run low", st);
        run_hold <= 1'b0;
        halt_rate <= 1;
        repeat (3) @(posedge i_clock);
        halt_rate <= 0;
        read_status("halt", st);
        read_status("halt", st2);
        if (!st[30]) stop_run("The halted flag did not set after a halt pulse.");
        if (st2[10:0] != st[10:0]) stop_run("The cycle count moved while halted.");

        run_hold <= 1'b1;
        axi_write(REG_CMD, CMD_CLEAR);
        read_all("clear");
        read_status("clear", st);

        run_hold  <= 1'b0;
        halt_rate <= 200;
        for (int n = 0; n < RAND_TXN; n++) begin
            case ($urandom_range(5))
                0:       axi_write(REG_CMD, $urandom_range(3));
                1:       axi_write(REG_SELECT, $urandom_range(9));
                2:       axi_write(AXI_ADDR_W'($urandom_range(3) * 4), $urandom);
                3, 4:    read_data("random");
                default: read_status("random", st);
            endcase
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: project.f
verilog/debug_pkg.sv
verilog/debug_if.sv
verilog/debug_axi_slave.sv
verilog/debug_sequencer.sv
verilog/debug_cycle_counter.sv
verilog/debug_database.sv
verilog/debug_top.sv
bench/debug_tb.sv

// File: verilog/debug_axi_slave.sv
module debug_axi_slave (
    input  logic                             i_clock,
    input  logic                             i_soft_reset,
    input  logic [debug_pkg::AXI_ADDR_W-1:0] i_awaddr,
    input  logic                             i_awvalid,
    output logic                             o_awready,
    input  logic [debug_pkg::DATA_W-1:0]     i_wdata,
    input  logic                             i_wvalid,
    output logic                             o_wready,
    output logic [1:0]                       o_bresp,
    output logic                             o_bvalid,
    input  logic                             i_bready,
    input  logic [debug_pkg::AXI_ADDR_W-1:0] i_araddr,
    input  logic                             i_arvalid,
    output logic                             o_arready,
    output logic [debug_pkg::DATA_W-1:0]     o_rdata,
    output logic [1:0]                       o_rresp,
    output logic                             o_rvalid,
    input  logic                             i_rready,
    output logic                             o_req,
    output debug_pkg::debug_cmd_e            o_req_cmd,
    output debug_pkg::debug_word_e           o_req_word,
    input  logic                             i_busy,
    input  logic [debug_pkg::DATA_W-1:0]     i_word,
    input  logic                             i_captured,
    input  logic                             i_halted,
    input  logic [debug_pkg::CYCLE_W-1:0]    i_cycles
);
    import debug_pkg::*;

    logic hold;

    // Busy, or a request issued last cycle that the sequencer has not yet seen.
    assign hold = i_busy || o_req;

    // Ready only in the handshake cycle, so it doubles as the accept strobe.
    assign o_awready = i_awvalid && i_wvalid && !o_bvalid && !hold;
    assign o_wready  = o_awready;
    assign o_arready = i_arvalid && !o_rvalid && !hold;

    //////////////////////////////////////////////////////////////////////
    // Write channel.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_bvalid   <= 1'b0;
            o_bresp    <= RESP_OKAY;
            o_req      <= 1'b0;
            o_req_cmd  <= CMD_NOP;
            o_req_word <= W_PC_CYCLES;
        end else begin
            o_req <= 1'b0;                               // One-cycle pulse.
            if (o_bvalid && i_bready) begin
                o_bvalid <= 1'b0;
            end
            if (o_awready) begin
                o_bvalid <= 1'b1;
                o_bresp  <= RESP_OKAY;
                case (i_awaddr)
                    REG_CMD: begin
                        if (i_wdata[DATA_W-1:2] != '0 || i_wdata[1:0] == 2'b11) begin
                            o_bresp <= RESP_SLVERR;
                        end else if (i_wdata[1:0] != CMD_NOP) begin
                            o_req     <= 1'b1;
                            o_req_cmd <= debug_cmd_e'(i_wdata[1:0]);
                        end
                    end
                    REG_SELECT: begin
                        if (i_wdata[DATA_W-1:3] != '0) begin
                            o_bresp <= RESP_SLVERR;   // Selection kept.
                        end else begin
                            o_req      <= 1'b1;
                            o_req_cmd  <= CMD_NOP;    // NOP with a request means load.
                            o_req_word <= debug_word_e'(i_wdata[2:0]);
                        end
                    end
                    default: o_bresp <= RESP_SLVERR;  // DATA and STATUS are read only.
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read channel.
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_rvalid <= 1'b0;
            o_rresp  <= RESP_OKAY;
            o_rdata  <= '0;
        end else begin
            if (o_rvalid && i_rready) begin
                o_rvalid <= 1'b0;
            end
            if (o_arready) begin
                o_rvalid <= 1'b1;
                o_rresp  <= RESP_OKAY;
                case (i_araddr)
                    REG_DATA:   o_rdata <= i_word;
                    REG_STATUS: begin
                        o_rdata <= {i_captured, i_halted,
                                    {(DATA_W-2-CYCLE_W){1'b0}}, i_cycles};
                    end
                    REG_CMD, REG_SELECT: o_rdata <= '0;
                    default: begin
                        o_rdata <= '0;
                        o_rresp <= RESP_SLVERR;
                    end
                endcase
            end
        end
    end

    // Responses stay up until the host takes them.
    a_bvalid_hold: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
        o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));
    a_rvalid_hold: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

endmodule

// File: verilog/debug_cycle_counter.sv
module debug_cycle_counter (
    input  logic                          i_clock,
    input  logic                          i_soft_reset,
    input  logic                          i_run,
    input  logic                          i_halt_wb,
    input  logic                          i_clear,
    output logic [debug_pkg::CYCLE_W-1:0] o_cycles,
    output logic                          o_halted
);
    import debug_pkg::*;

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset || i_clear) begin
            o_cycles <= '0;
            o_halted <= 1'b0;
        end else begin
            if (i_halt_wb) begin
                o_halted <= 1'b1;                        // Sticky until clear.
            end
            // Saturates at the top count.
            if (i_run && !o_halted && o_cycles != {CYCLE_W{1'b1}}) begin
                o_cycles <= o_cycles + 1'b1;
            end
        end
    end

    a_frozen: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
        o_halted && !i_clear |=> $stable(o_cycles));

endmodule

// File: verilog/debug_database.sv
module debug_database (
    input  logic                          i_clock,
    input  logic                          i_soft_reset,
    snapshot_if.capture                   probe,
    input  logic [debug_pkg::CYCLE_W-1:0] i_cycles,
    db_ctrl_if.db                         ctrl
);
    import debug_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Capture registers.
    //////////////////////////////////////////////////////////////////////

    logic [ADDR_W-1:0]    pc_q;
    logic [ADDR_W-1:0]    adder_pc_q;
    logic [DATA_W-1:0]    instr_q;
    logic [DATA_W-1:0]    data_a_q;
    logic [DATA_W-1:0]    data_b_q;
    logic [DATA_W-1:0]    alu_q;
    logic [DATA_W-1:0]    wb_data_q;
    logic [REG_IDX_W-1:0] wb_dest_q;
    logic                 wb_reg_write_q;
    logic                 halt_q;
    logic [CYCLE_W-1:0]   cycles_q;

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset || ctrl.clear) begin
            pc_q           <= '0;
            adder_pc_q     <= '0;
            instr_q        <= '0;
            data_a_q       <= '0;
            data_b_q       <= '0;
            alu_q          <= '0;
            wb_data_q      <= '0;
            wb_dest_q      <= '0;
            wb_reg_write_q <= 1'b0;
            halt_q         <= 1'b0;
            cycles_q       <= '0;
            ctrl.word      <= '0;
        end else begin
            if (ctrl.capture) begin
                pc_q           <= probe.pc;
                adder_pc_q     <= probe.adder_pc;
                instr_q        <= probe.instr;
                data_a_q       <= probe.data_a;
                data_b_q       <= probe.data_b;
                alu_q          <= probe.alu_result;
                wb_data_q      <= probe.wb_data;
                wb_dest_q      <= probe.wb_dest;
                wb_reg_write_q <= probe.wb_reg_write;
                halt_q         <= probe.halt_wb;
                cycles_q       <= i_cycles;              // Count of this very cycle.
            end

            //////////////////////////////////////////////////////////////
            // Packed word output.
            //////////////////////////////////////////////////////////////
            if (ctrl.load) begin
                case (ctrl.word_sel)
                    W_PC_CYCLES: begin
                        ctrl.word <= {pc_q, {(DATA_W-ADDR_W-CYCLE_W){1'b0}}, cycles_q};
                    end
                    W_ADDER_PC:  ctrl.word <= {{(DATA_W-ADDR_W){1'b0}}, adder_pc_q};
                    W_INSTR:     ctrl.word <= instr_q;
                    W_DATA_A:    ctrl.word <= data_a_q;
                    W_DATA_B:    ctrl.word <= data_b_q;
                    W_ALU:       ctrl.word <= alu_q;
                    W_WB_DATA:   ctrl.word <= wb_data_q;
                    default: begin                       // Write-back control.
                        ctrl.word <= {halt_q, wb_reg_write_q,
                                      {(DATA_W-2-REG_IDX_W){1'b0}}, wb_dest_q};
                    end
                endcase
            end
        end
    end

    // The FSM issues one operation at a time.
    a_one_op: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
        !(ctrl.capture && ctrl.clear));

endmodule

// File: verilog/debug_if.sv
// Pipeline latch values seen by the snapshot unit.
interface snapshot_if;
    import debug_pkg::*;

    logic [ADDR_W-1:0]    pc;
    logic [ADDR_W-1:0]    adder_pc;
    logic [DATA_W-1:0]    instr;
    logic [DATA_W-1:0]    data_a;
    logic [DATA_W-1:0]    data_b;
    logic [DATA_W-1:0]    alu_result;
    logic [DATA_W-1:0]    wb_data;
    logic [REG_IDX_W-1:0] wb_dest;
    logic                 wb_reg_write;
    logic                 halt_wb;

    modport source (output pc, adder_pc, instr, data_a, data_b, alu_result,
                    wb_data, wb_dest, wb_reg_write, halt_wb);
    modport capture (input pc, adder_pc, instr, data_a, data_b, alu_result,
                     wb_data, wb_dest, wb_reg_write, halt_wb);
endinterface

// Sequencer strobes into the database and the word coming back.
interface db_ctrl_if;
    import debug_pkg::*;

    logic              capture;
    logic              clear;
    logic              load;
    debug_word_e       word_sel;
    logic [DATA_W-1:0] word;

    modport seq (output capture, clear, load, word_sel);
    modport db (input capture, clear, load, word_sel, output word);
endinterface

// File: verilog/debug_pkg.sv
package debug_pkg;

    // Datapath widths of the MIPS core.
    localparam int ADDR_W     = 11;
    localparam int DATA_W     = 32;
    localparam int REG_IDX_W  = 5;
    localparam int CYCLE_W    = 11;                 // Same as the PC so both share one word.
    localparam int AXI_ADDR_W = 4;

    // Register map, byte offsets.
    localparam logic [AXI_ADDR_W-1:0] REG_CMD    = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_SELECT = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_DATA   = 4'h8;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'hC;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Commands written to REG_CMD. Value 3 is illegal.
    typedef enum logic [1:0] {
        CMD_NOP     = 2'd0,
        CMD_CAPTURE = 2'd1,
        CMD_CLEAR   = 2'd2
    } debug_cmd_e;

    // Snapshot words, in register order.
    typedef enum logic [2:0] {
        W_PC_CYCLES = 3'd0,
        W_ADDER_PC  = 3'd1,
        W_INSTR     = 3'd2,
        W_DATA_A    = 3'd3,
        W_DATA_B    = 3'd4,
        W_ALU       = 3'd5,
        W_WB_DATA   = 3'd6,
        W_WB_CTRL   = 3'd7
    } debug_word_e;

    typedef enum logic [2:0] {
        S_IDLE    = 3'd0,
        S_CAPTURE = 3'd1,
        S_CLEAR   = 3'd2,
        S_LOAD    = 3'd3,
        S_DONE    = 3'd4
    } seq_state_e;

endpackage

// File: verilog/debug_sequencer.sv
module debug_sequencer (
    input  logic                   i_clock,
    input  logic                   i_soft_reset,
    input  logic                   i_req,
    input  debug_pkg::debug_cmd_e  i_req_cmd,
    input  debug_pkg::debug_word_e i_req_word,
    output logic                   o_busy,
    output logic                   o_captured,
    db_ctrl_if.seq                 ctrl
);
    import debug_pkg::*;

    seq_state_e  state;
    seq_state_e  state_next;
    debug_word_e sel_q;                                  // Current word selection.

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (i_req) begin
                    case (i_req_cmd)
                        CMD_CAPTURE: state_next = S_CAPTURE;
                        CMD_CLEAR:   state_next = S_CLEAR;
                        default:     state_next = S_LOAD;
                    endcase
                end
            end
            S_CAPTURE, S_CLEAR, S_LOAD: state_next = S_DONE;
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            state      <= S_IDLE;
            sel_q      <= W_PC_CYCLES;
            o_captured <= 1'b0;
        end else begin
            state <= state_next;
            if (state == S_IDLE && i_req && i_req_cmd == CMD_NOP) begin
                sel_q <= i_req_word;
            end
            if (state == S_CAPTURE) begin
                o_captured <= 1'b1;
            end else if (state == S_CLEAR) begin
                o_captured <= 1'b0;
            end
        end
    end

    assign o_busy        = (state != S_IDLE);
    assign ctrl.capture  = (state == S_CAPTURE);
    assign ctrl.clear    = (state == S_CLEAR);
    // Done refreshes the word too, so a capture is visible at once.
    assign ctrl.load     = (state == S_LOAD) || (state == S_DONE);
    assign ctrl.word_sel = sel_q;

    // The slave must hold off the bus while an operation runs.
    a_no_req_busy: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
        o_busy |-> !i_req);

endmodule

// File: verilog/debug_top.sv
module debug_top (
    input  logic                             i_clock,
    input  logic                             i_soft_reset,
    input  logic [debug_pkg::AXI_ADDR_W-1:0] i_awaddr,
    input  logic                             i_awvalid,
    output logic                             o_awready,
    input  logic [debug_pkg::DATA_W-1:0]     i_wdata,
    input  logic                             i_wvalid,
    output logic                             o_wready,
    output logic [1:0]                       o_bresp,
    output logic                             o_bvalid,
    input  logic                             i_bready,
    input  logic [debug_pkg::AXI_ADDR_W-1:0] i_araddr,
    input  logic                             i_arvalid,
    output logic                             o_arready,
    output logic [debug_pkg::DATA_W-1:0]     o_rdata,
    output logic [1:0]                       o_rresp,
    output logic                             o_rvalid,
    input  logic                             i_rready,
    input  logic [debug_pkg::ADDR_W-1:0]     i_pc,
    input  logic [debug_pkg::ADDR_W-1:0]     i_adder_pc,
    input  logic [debug_pkg::DATA_W-1:0]     i_instr,
    input  logic [debug_pkg::DATA_W-1:0]     i_data_a,
    input  logic [debug_pkg::DATA_W-1:0]     i_data_b,
    input  logic [debug_pkg::DATA_W-1:0]     i_alu_result,
    input  logic [debug_pkg::DATA_W-1:0]     i_wb_data,
    input  logic [debug_pkg::REG_IDX_W-1:0]  i_wb_dest,
    input  logic                             i_wb_reg_write,
    input  logic                             i_halt_wb,
    input  logic                             i_run
);
    import debug_pkg::*;

    logic               req;
    debug_cmd_e         req_cmd;
    debug_word_e        req_word;
    logic               busy;
    logic               captured;
    logic               halted;
    logic [CYCLE_W-1:0] cycles;

    snapshot_if snap ();
    db_ctrl_if  db_ctrl ();

    // Probe ports into the snapshot bundle.
    assign snap.pc           = i_pc;
    assign snap.adder_pc     = i_adder_pc;
    assign snap.instr        = i_instr;
    assign snap.data_a       = i_data_a;
    assign snap.data_b       = i_data_b;
    assign snap.alu_result   = i_alu_result;
    assign snap.wb_data      = i_wb_data;
    assign snap.wb_dest      = i_wb_dest;
    assign snap.wb_reg_write = i_wb_reg_write;
    assign snap.halt_wb      = i_halt_wb;

    debug_axi_slave u_axi (
        .i_clock(i_clock), .i_soft_reset(i_soft_reset),
        .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
        .i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
        .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
        .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
        .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
        .o_req(req), .o_req_cmd(req_cmd), .o_req_word(req_word), .i_busy(busy),
        .i_word(db_ctrl.word), .i_captured(captured), .i_halted(halted),
        .i_cycles(cycles)
    );

    debug_sequencer u_seq (
        .i_clock(i_clock), .i_soft_reset(i_soft_reset),
        .i_req(req), .i_req_cmd(req_cmd), .i_req_word(req_word),
        .o_busy(busy), .o_captured(captured), .ctrl(db_ctrl.seq)
    );

    debug_cycle_counter u_cnt (
        .i_clock(i_clock), .i_soft_reset(i_soft_reset),
        .i_run(i_run), .i_halt_wb(i_halt_wb), .i_clear(db_ctrl.clear),
        .o_cycles(cycles), .o_halted(halted)
    );

    debug_database u_db (
        .i_clock(i_clock), .i_soft_reset(i_soft_reset),
        .probe(snap.capture), .i_cycles(cycles), .ctrl(db_ctrl.db)
    );

endmodule
